/* logic/membus_pkg.sv */
`default_nettype none

package membus_pkg;

  //////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////

  localparam int line_addr_w  = 26;  // line address is byte address bits 29:4.
  localparam int word_sel_lsb = 2;   // word select is byte address bits 3:2.
  localparam int line_w       = 128;

  //////////////////////////////////////////////////
  // processor bus
  //////////////////////////////////////////////////

  typedef struct packed {
    logic        write;
    logic [31:0] addr;   // byte address.
    logic [31:0] data;
    logic [3:0]  be;     // write byte enables, ignored on reads.
  } membus_req_t;

  //////////////////////////////////////////////////
  // memory side
  //////////////////////////////////////////////////

  // word 0 sits in the low bits.
  typedef logic [line_w/32-1:0][31:0] line_t;

  typedef struct packed {
    logic                   write;
    logic [line_addr_w-1:0] line_addr;
    line_t                  data;       // zero for a fetch.
  } mem_cmd_t;

endpackage

`default_nettype wire

/* logic/line_buffer_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module line_buffer_ctrl (
  input  logic                      clk,
  input  logic                      rst,

  input  logic                      i_req,
  input  membus_pkg::membus_req_t   i_bus,
  output logic                      o_ack,
  output logic [31:0]               o_rdata,

  output logic                      o_cmd_push,
  output membus_pkg::mem_cmd_t      o_cmd,

  input  logic                      i_line_valid,
  input  membus_pkg::line_t         i_line,
  output logic                      o_line_pop
);

  import membus_pkg::*;

  localparam logic [4:0] st_idle       = 5'b00001;
  localparam logic [4:0] st_wb         = 5'b00010;
  localparam logic [4:0] st_fetch      = 5'b00100;
  localparam logic [4:0] st_fetch_wait = 5'b01000;
  localparam logic [4:0] st_update     = 5'b10000;

  logic [4:0]             state;

  membus_req_t            req_q;      // request held for the whole transaction.
  logic                   buf_valid;
  logic [line_addr_w-1:0] buf_addr;
  line_t                  buf_line;

  logic [line_addr_w-1:0] bus_line;
  logic [line_addr_w-1:0] req_line;
  logic [1:0]             word_sel;
  logic                   hit;

  assign bus_line = i_bus.addr[word_sel_lsb+2 +: line_addr_w];
  assign req_line = req_q.addr[word_sel_lsb+2 +: line_addr_w];
  assign word_sel = req_q.addr[word_sel_lsb +: 2];
  assign hit      = buf_valid && (buf_addr == bus_line);

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= st_idle;
      buf_valid <= 1'b0;
      o_ack     <= 1'b0;
    end
    else
    begin
      o_ack <= 1'b0;
      unique case (1'b1)
        state[0]:
        begin
          if (i_req)
          begin
            if (hit)
              state <= st_update;
            else if (buf_valid)
              state <= st_wb;        // held line is always dirty.
            else
              state <= st_fetch;
          end
        end
        state[1]: state <= st_fetch;
        state[2]:
        begin
          buf_valid <= 1'b0;
          state     <= st_fetch_wait;
        end
        state[3]:
        begin
          if (i_line_valid)
          begin
            buf_valid <= 1'b1;
            state     <= st_update;
          end
        end
        state[4]:
        begin
          o_ack <= 1'b1;
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // line and request storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (state[0] && i_req)
      req_q <= i_bus;
    if (state[2])
      buf_addr <= req_line;
    if (o_line_pop)
      buf_line <= i_line;
    if (state[4])
    begin
      if (req_q.write)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (req_q.be[b])
            buf_line[word_sel][8*b +: 8] <= req_q.data[8*b +: 8];
        end
      end
      else
      begin
        o_rdata <= buf_line[word_sel];
      end
    end
  end

  //////////////////////////////////////////////////
  // command and line queue side
  //////////////////////////////////////////////////

  assign o_cmd_push = state[1] | state[2];
  assign o_line_pop = state[3] & i_line_valid;

  always_comb
  begin
    o_cmd = '0;
    if (state[1])
    begin
      o_cmd.write     = 1'b1;        // full-line write-back.
      o_cmd.line_addr = buf_addr;
      o_cmd.data      = buf_line;
    end
    else
    begin
      o_cmd.line_addr = req_line;
    end
  end

  a_state_onehot : assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("line_buffer_ctrl state is not one-hot");

  // the master waits for o_ack, so a strobe in any other state is a protocol error.
  a_req_in_idle : assert property (@(posedge clk) disable iff (rst) i_req |-> state[0])
    else $error("request strobe while a transaction is in progress");

endmodule

`default_nettype wire

/* logic/sync_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     rst,

  input  logic     i_push,
  input  payload_t i_data,

  input  logic     i_pop,
  output payload_t o_data,
  output logic     o_empty
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             full;

  assign o_empty = (count == '0);
  assign full    = (count == cnt_w'(depth));
  assign o_data  = mem[rd_ptr];     // first word falls through.

  always_ff @(posedge clk)
  begin
    if (i_push)
      mem[wr_ptr] <= i_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (i_push)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (i_pop)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow : assert property (@(posedge clk) disable iff (rst)
    i_push && full |-> i_pop)
    else $error("push into a full queue");

  a_no_underflow : assert property (@(posedge clk) disable iff (rst)
    i_pop |-> !o_empty)
    else $error("pop from an empty queue");

endmodule

`default_nettype wire

/* logic/avl_issue.sv */
`timescale 1ns/100ps
`default_nettype none

module avl_issue (
  input  logic                                clk,
  input  logic                                rst,

  input  logic                                i_cmd_empty,
  input  membus_pkg::mem_cmd_t                i_cmd,
  output logic                                o_cmd_pop,

  input  logic                                i_avl_ready,
  output logic [membus_pkg::line_addr_w-1:0]  o_avl_addr,
  output logic [membus_pkg::line_w-1:0]       o_avl_wdata,
  output logic                                o_avl_read_req,
  output logic                                o_avl_write_req
);

  import membus_pkg::*;

  logic     busy;     // a command is held on the memory port.
  mem_cmd_t cmd_q;
  logic     accept;

  //////////////////////////////////////////////////
  // pop and hold
  //////////////////////////////////////////////////

  assign o_cmd_pop = ~i_cmd_empty & ~busy;
  assign accept    = busy & i_avl_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy <= 1'b0;
    end
    else
    begin
      if (o_cmd_pop)
        busy <= 1'b1;
      else if (accept)
        busy <= 1'b0;   // free for the next pop one cycle later.
    end
  end

  always_ff @(posedge clk)
  begin
    if (o_cmd_pop)
      cmd_q <= i_cmd;
  end

  //////////////////////////////////////////////////
  // memory port
  //////////////////////////////////////////////////

  assign o_avl_read_req  = busy & ~cmd_q.write;
  assign o_avl_write_req = busy &  cmd_q.write;
  assign o_avl_addr      = cmd_q.line_addr;
  assign o_avl_wdata     = cmd_q.data;

  // a request that is not taken must come back unchanged in the next cycle.
  a_stall_stable : assert property (@(posedge clk) disable iff (rst)
    (o_avl_read_req || o_avl_write_req) && !i_avl_ready
    |=> $stable(o_avl_addr) && $stable(o_avl_wdata)
        && $stable(o_avl_read_req) && $stable(o_avl_write_req))
    else $error("memory request changed while stalled");

endmodule

`default_nettype wire

/* logic/membus_ddr_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module membus_ddr_bridge #(
  parameter int cmd_depth   = 4,
  parameter int rdata_depth = 2
) (
  input  logic                                clk,
  input  logic                                rst,

  input  logic                                i_req,
  input  membus_pkg::membus_req_t             i_bus,
  output logic                                o_ack,
  output logic [31:0]                         o_rdata,

  input  logic                                i_avl_ready,
  output logic [membus_pkg::line_addr_w-1:0]  o_avl_addr,
  output logic [membus_pkg::line_w-1:0]       o_avl_wdata,
  output logic                                o_avl_read_req,
  output logic                                o_avl_write_req,
  input  logic                                i_avl_rdata_valid,
  input  logic [membus_pkg::line_w-1:0]       i_avl_rdata
);

  import membus_pkg::*;

  logic     cmd_push;
  mem_cmd_t cmd_in;
  logic     cmd_pop;
  mem_cmd_t cmd_out;
  logic     cmd_empty;

  logic     line_pop;
  line_t    line_out;
  logic     line_empty;

  line_buffer_ctrl u_ctrl (
    .clk          ( clk         ),
    .rst          ( rst         ),
    .i_req        ( i_req       ),
    .i_bus        ( i_bus       ),
    .o_ack        ( o_ack       ),
    .o_rdata      ( o_rdata     ),
    .o_cmd_push   ( cmd_push    ),
    .o_cmd        ( cmd_in      ),
    .i_line_valid ( ~line_empty ),
    .i_line       ( line_out    ),
    .o_line_pop   ( line_pop    )
  );

  sync_fifo #(.payload_t(mem_cmd_t), .depth(cmd_depth)) u_cmd_fifo (
    .clk     ( clk       ),
    .rst     ( rst       ),
    .i_push  ( cmd_push  ),
    .i_data  ( cmd_in    ),
    .i_pop   ( cmd_pop   ),
    .o_data  ( cmd_out   ),
    .o_empty ( cmd_empty )
  );

  // every returned beat is one whole line.
  sync_fifo #(.payload_t(line_t), .depth(rdata_depth)) u_rdata_fifo (
    .clk     ( clk               ),
    .rst     ( rst               ),
    .i_push  ( i_avl_rdata_valid ),
    .i_data  ( i_avl_rdata       ),
    .i_pop   ( line_pop          ),
    .o_data  ( line_out          ),
    .o_empty ( line_empty        )
  );

  avl_issue u_issue (
    .clk             ( clk             ),
    .rst             ( rst             ),
    .i_cmd_empty     ( cmd_empty       ),
    .i_cmd           ( cmd_out         ),
    .o_cmd_pop       ( cmd_pop         ),
    .i_avl_ready     ( i_avl_ready     ),
    .o_avl_addr      ( o_avl_addr      ),
    .o_avl_wdata     ( o_avl_wdata     ),
    .o_avl_read_req  ( o_avl_read_req  ),
    .o_avl_write_req ( o_avl_write_req )
  );

endmodule

`default_nettype wire

/* dv/avl_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module avl_mem_model #(
  parameter int read_lat = 3
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [membus_pkg::line_addr_w-1:0] i_addr,
  input  logic [membus_pkg::line_w-1:0]      i_wdata,
  input  logic                               i_read_req,
  input  logic                               i_write_req,
  output logic                               o_ready,
  output logic                               o_rdata_valid,
  output logic [membus_pkg::line_w-1:0]      o_rdata
);

  import membus_pkg::*;

  logic [line_w-1:0] mem [logic [line_addr_w-1:0]];   // lines never written read as zero.
  logic [line_w-1:0] rd_data_q [$];
  longint            rd_due_q [$];
  longint            cycle;
  integer            seed;

  initial
  begin
    seed          = 27;
    cycle         = 0;
    o_ready       = 1'b0;
    o_rdata_valid = 1'b0;
    o_rdata       = '0;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      cycle = 0;
      rd_data_q.delete();
      rd_due_q.delete();
    end
    else
    begin
      cycle = cycle + 1;
      if (o_ready && i_write_req)
        mem[i_addr] = i_wdata;
      if (o_ready && i_read_req)
      begin
        rd_data_q.push_back(mem.exists(i_addr) ? mem[i_addr] : '0);
        rd_due_q.push_back(cycle + read_lat + {$random(seed)} % 3);
      end
    end
  end

  // ready and read data move on the falling edge to stay half a cycle away from the DUT.
  always @(negedge clk)
  begin
    o_rdata_valid = 1'b0;
    o_ready       = 1'b0;
    if (!rst)
    begin
      o_ready = ({$random(seed)} % 4) != 0;   // about one cycle in four is a stall.
      if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle)
      begin
        o_rdata_valid = 1'b1;
        o_rdata       = rd_data_q.pop_front();
        void'(rd_due_q.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

/* dv/bridge_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module bridge_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_req,
  input  membus_pkg::membus_req_t i_bus,
  input  logic                    i_ack,
  input  logic [31:0]             i_rdata,
  input  logic                    i_avl_read_req,
  input  logic                    i_avl_write_req,
  input  logic [31:0]             i_exp_rdata,
  input  logic                    i_exp_hit,
  output int                      o_errors
);

  import membus_pkg::*;

  logic [31:0] ref_mem [logic [27:0]];   // keyed by byte address bits 29:2.
  membus_req_t pend_req;
  logic [31:0] pend_exp;
  logic [31:0] ref_word;
  logic        pend_hit;
  logic        pending;
  logic        seen_req;
  int          cycles;

  function automatic logic [31:0] ref_read(input logic [27:0] key);
    return ref_mem.exists(key) ? ref_mem[key] : 32'h0;
  endfunction

  initial
    o_errors = 0;

  always @(posedge clk)
  begin
    if (rst)
    begin
      pending  = 1'b0;
      seen_req = 1'b0;
    end
    else
    begin
      if (!seen_req && (i_ack || i_avl_read_req || i_avl_write_req))
      begin
        $display("at %0t an acknowledge or memory request was high before any bus request", $time);
        o_errors++;
      end
      if (i_ack && !pending)
      begin
        $display("at %0t the bridge acknowledged with no request outstanding", $time);
        o_errors++;
      end
      else if (pending)
      begin
        cycles++;
        if (i_ack)
        begin
          pending  = 1'b0;
          ref_word = ref_read(pend_req.addr[29:2]);
          if (!pend_req.write && i_rdata !== ref_word)
          begin
            $display("mismatch at %0t: read %h returned %h, reference memory holds %h",
                     $time, pend_req.addr, i_rdata, ref_word);
            o_errors++;
          end
          if (!pend_req.write && i_rdata !== pend_exp)
          begin
            $display("mismatch at %0t: read %h returned %h, stimulus expects %h",
                     $time, pend_req.addr, i_rdata, pend_exp);
            o_errors++;
          end
          if (pend_hit && cycles != 2)
          begin
            $display("mismatch at %0t: hit on %h acknowledged after %0d cycles, expected 2",
                     $time, pend_req.addr, cycles);
            o_errors++;
          end
        end
      end
      if (i_req)
      begin
        seen_req = 1'b1;
        pending  = 1'b1;
        cycles   = 0;
        pend_req = i_bus;
        pend_exp = i_exp_rdata;
        pend_hit = i_exp_hit;
        if (i_bus.write)
        begin
          ref_word = ref_read(i_bus.addr[29:2]);
          for (int b = 0; b < 4; b++)
          begin
            if (i_bus.be[b])
              ref_word[8*b +: 8] = i_bus.data[8*b +: 8];
          end
          ref_mem[i_bus.addr[29:2]] = ref_word;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_membus_ddr_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_membus_ddr_bridge;

  import membus_pkg::*;

  localparam int ack_timeout = 200;   // cycles allowed for one access.

  logic                   clk;
  logic                   rst;
  logic                   req;
  membus_req_t            bus;
  logic                   ack;
  logic [31:0]            rdata;
  logic                   avl_ready;
  logic [line_addr_w-1:0] avl_addr;
  logic [line_w-1:0]      avl_wdata;
  logic                   avl_read_req;
  logic                   avl_write_req;
  logic                   avl_rdata_valid;
  logic [line_w-1:0]      avl_rdata;
  logic [31:0]            exp_rdata;
  logic                   exp_hit;
  int                     chk_errors;

  int                     tests;
  int                     failed;
  logic                   timed_out;
  int                     fd;
  logic [8*128-1:0]       text;
  int                     f_wr;
  int                     f_hit;
  logic [31:0]            f_addr;
  logic [31:0]            f_data;
  logic [31:0]            f_exp;
  logic [3:0]             f_be;

  membus_ddr_bridge #(.cmd_depth(4), .rdata_depth(2)) uut (
    .clk               ( clk             ),
    .rst               ( rst             ),
    .i_req             ( req             ),
    .i_bus             ( bus             ),
    .o_ack             ( ack             ),
    .o_rdata           ( rdata           ),
    .i_avl_ready       ( avl_ready       ),
    .o_avl_addr        ( avl_addr        ),
    .o_avl_wdata       ( avl_wdata       ),
    .o_avl_read_req    ( avl_read_req    ),
    .o_avl_write_req   ( avl_write_req   ),
    .i_avl_rdata_valid ( avl_rdata_valid ),
    .i_avl_rdata       ( avl_rdata       )
  );

  avl_mem_model u_mem (
    .clk           ( clk             ),
    .rst           ( rst             ),
    .i_addr        ( avl_addr        ),
    .i_wdata       ( avl_wdata       ),
    .i_read_req    ( avl_read_req    ),
    .i_write_req   ( avl_write_req   ),
    .o_ready       ( avl_ready       ),
    .o_rdata_valid ( avl_rdata_valid ),
    .o_rdata       ( avl_rdata       )
  );

  bridge_checker u_check (
    .clk             ( clk           ),
    .rst             ( rst           ),
    .i_req           ( req           ),
    .i_bus           ( bus           ),
    .i_ack           ( ack           ),
    .i_rdata         ( rdata         ),
    .i_avl_read_req  ( avl_read_req  ),
    .i_avl_write_req ( avl_write_req ),
    .i_exp_rdata     ( exp_rdata     ),
    .i_exp_hit       ( exp_hit       ),
    .o_errors        ( chk_errors    )
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // one bus access, strobe to acknowledge
  //////////////////////////////////////////////////

  task automatic run_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be, input logic [31:0] exp, input logic hit);
    int waited;
    int errs_before;
    errs_before = chk_errors;
    waited      = 0;
    @(negedge clk);
    req       = 1'b1;
    bus.write = wr;
    bus.addr  = addr;
    bus.data  = data;
    bus.be    = be;
    exp_rdata = exp;
    exp_hit   = hit;
    @(negedge clk);
    req = 1'b0;
    while (!ack && waited < ack_timeout)
    begin
      @(negedge clk);
      waited++;
    end
    tests++;
    if (!ack)
    begin
      $display("test %0d timed out waiting for an acknowledge on address %h", tests, addr);
      timed_out = 1'b1;
      failed++;
    end
    else
    begin
      @(negedge clk);   // the checker compares on the edge after the acknowledge.
      if (chk_errors != errs_before)
      begin
        failed++;
        $display("test %0d %s %h FAILED", tests, wr ? "write" : "read", addr);
      end
      else
      begin
        $display("test %0d %s %h ok", tests, wr ? "write" : "read", addr);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus file loop
  //////////////////////////////////////////////////

  initial
  begin
    rst       = 1'b1;
    req       = 1'b0;
    bus       = '0;
    exp_rdata = '0;
    exp_hit   = 1'b0;
    tests     = 0;
    failed    = 0;
    timed_out = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);   // idle so the post-reset levels get watched.
    fd = $fopen("dv/bridge_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the stimulus file dv/bridge_stimulus.txt");
      failed++;
    end
    else
    begin
      while (!$feof(fd) && !timed_out)
      begin
        text = '0;
        if ($fgets(text, fd) != 0
            && $sscanf(text, "%d %h %h %h %h %d", f_wr, f_addr, f_data, f_be, f_exp, f_hit) == 6)
          run_access(f_wr != 0, f_addr, f_data, f_be, f_exp, f_hit != 0);
      end
      $fclose(fd);
    end
    $display("tests run %0d, failed %0d, checker errors %0d", tests, failed, chk_errors);
    if (failed == 0 && chk_errors == 0 && tests > 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/bridge_stimulus.txt */
// columns: wr addr data be exp_rdata hit
// wr 1 is a write, exp_rdata is checked on reads, hit 1 expects a two-cycle acknowledge
0 00000010 00000000 0 00000000 0
1 00000014 deadbeef f 00000000 1
0 00000014 00000000 0 deadbeef 1
1 00000018 11223344 f 00000000 1
1 00000018 aabbccdd 5 00000000 1
0 00000018 00000000 0 11bb33dd 1
1 00000100 cafef00d f 00000000 0
0 00000014 00000000 0 deadbeef 0
0 00000018 00000000 0 11bb33dd 1
0 00000100 00000000 0 cafef00d 0
1 0000a00c 0badc0de c 00000000 0
0 0000a00c 00000000 0 0bad0000 1
0 0000a000 00000000 0 00000000 1
1 00200004 12345678 3 00000000 0
0 0000a00c 00000000 0 0bad0000 0
0 00200004 00000000 0 00005678 0
0 00000104 00000000 0 00000000 0
0 00000010 00000000 0 00000000 0

/* verilog.f */
logic/membus_pkg.sv
logic/line_buffer_ctrl.sv
logic/sync_fifo.sv
logic/avl_issue.sv
logic/membus_ddr_bridge.sv
dv/avl_mem_model.sv
dv/bridge_checker.sv
dv/tb_membus_ddr_bridge.sv

/* Bender.yml */
package:
  name: membus_ddr_bridge

sources:
  - logic/membus_pkg.sv
  - logic/line_buffer_ctrl.sv
  - logic/sync_fifo.sv
  - logic/avl_issue.sv
  - logic/membus_ddr_bridge.sv
  - target: test
    files:
      - dv/avl_mem_model.sv
      - dv/bridge_checker.sv
      - dv/tb_membus_ddr_bridge.sv
